/* logic/msg_pkg.sv */
`default_nettype none

package msg_pkg;

    localparam int MSG_MAX       = 32;
    localparam int SETTLE_CYCLES = 4;  // Digit settle delay after a command

    typedef logic [7:0]                   char_t;
    typedef logic [$clog2(MSG_MAX)-1:0]   idx_t;
    typedef logic [$clog2(MSG_MAX):0]     len_t;
    typedef logic [MSG_MAX-1:0][7:0]      msg_text_t;  // First char in the highest used byte

    localparam char_t CMD_CLOCK     = "C";
    localparam char_t CMD_STOPWATCH = "W";
    localparam char_t CHAR_LF       = 8'h0A;

    localparam logic [3:0] MODE_STOPWATCH  = 4'b0001;
    localparam logic [3:0] MODE_CLOCK_MASK = 4'b1101;  // Clock mode when these bits are zero

    localparam len_t LEN_CLOCK_RPT = 6'd18;
    localparam len_t LEN_SW_RPT    = 6'd23;

    typedef enum logic {
        REPORT_CLOCK,
        REPORT_STOPWATCH
    } report_kind_t;

    typedef enum logic [2:0] {
        EV_RIGHT,
        EV_LEFT,
        EV_DOWN,
        EV_UP,
        EV_SW_RUN,
        EV_SW_STOP,
        EV_SW_CLEAR
    } event_kind_t;

    // Character at position idx of a right-aligned text of len characters
    function automatic char_t text_char(msg_text_t text, len_t len, idx_t idx);
        idx_t pos;
        pos = idx_t'(len - len_t'(1)) - idx;
        if (len_t'(idx) < len) begin
            return text[pos];
        end
        return char_t'(0);  // Past the end
    endfunction

endpackage

`default_nettype wire

/* logic/report_builder.sv */
`timescale 1ns/100ps
`default_nettype none

module report_builder (
    input  wire                 iClk,
    input  wire                 iRst,
    input  wire msg_pkg::char_t rx_data,
    input  wire                 rx_valid,
    input  wire msg_pkg::char_t hour_10,
    input  wire msg_pkg::char_t hour_1,
    input  wire msg_pkg::char_t min_10,
    input  wire msg_pkg::char_t min_1,
    input  wire msg_pkg::char_t sec_10,
    input  wire msg_pkg::char_t sec_1,
    output logic                req,
    output msg_pkg::len_t       len,
    input  wire                 grant,
    input  wire msg_pkg::idx_t  char_idx,
    output msg_pkg::char_t      char_out
);

    localparam int CNT_W = $clog2(msg_pkg::SETTLE_CYCLES + 1);

    msg_pkg::report_kind_t kind;
    logic [CNT_W-1:0]      settle_cnt;
    logic                  settling;
    logic                  serving;    // Granted and still being streamed
    logic                  settle_done;
    logic                  cmd_hit;
    logic                  last_read;

    msg_pkg::char_t h10_q, h1_q, m10_q, m1_q, s10_q, s1_q;
    msg_pkg::msg_text_t text;

    assign cmd_hit = rx_valid && !settling && !req && !serving &&
                     (rx_data == msg_pkg::CMD_CLOCK || rx_data == msg_pkg::CMD_STOPWATCH);

    assign settle_done = settling && (settle_cnt == '0);
    assign last_read   = serving && (msg_pkg::len_t'(char_idx) == len - msg_pkg::len_t'(1));

    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            kind       <= msg_pkg::REPORT_CLOCK;
            settle_cnt <= '0;
            settling   <= 1'b0;
            req        <= 1'b0;
            serving    <= 1'b0;
        end else begin
            if (cmd_hit) begin
                kind       <= (rx_data == msg_pkg::CMD_CLOCK) ? msg_pkg::REPORT_CLOCK
                                                              : msg_pkg::REPORT_STOPWATCH;
                settling   <= 1'b1;
                settle_cnt <= CNT_W'(msg_pkg::SETTLE_CYCLES - 1);
            end else if (settle_done) begin
                settling <= 1'b0;
                req      <= 1'b1;  // Same edge as the digit capture
            end else if (settling) begin
                settle_cnt <= settle_cnt - CNT_W'(1);
            end

            if (grant) begin
                req     <= 1'b0;
                serving <= 1'b1;
            end else if (last_read) begin
                serving <= 1'b0;
            end
        end
    end

    always_ff @(posedge iClk) begin
        if (settle_done) begin
            h10_q <= hour_10;
            h1_q  <= hour_1;
            m10_q <= min_10;
            m1_q  <= min_1;
            s10_q <= sec_10;
            s1_q  <= sec_1;
        end
    end

    always_comb begin
        if (kind == msg_pkg::REPORT_CLOCK) begin
            len  = msg_pkg::LEN_CLOCK_RPT;
            text = msg_pkg::msg_text_t'({"Clock ", h10_q, h1_q, "H ", m10_q, m1_q, "M ",
                                         s10_q, s1_q, "S", msg_pkg::CHAR_LF});
        end else begin
            // Stopwatch digits are minutes, seconds and centiseconds
            len  = msg_pkg::LEN_SW_RPT;
            text = msg_pkg::msg_text_t'({"Stopwatch ", h10_q, h1_q, "M ", m10_q, m1_q, "S ",
                                         s10_q, s1_q, "mS", msg_pkg::CHAR_LF});
        end
    end

    assign char_out = msg_pkg::text_char(text, len, char_idx);

endmodule

`default_nettype wire

/* logic/event_builder.sv */
`timescale 1ns/100ps
`default_nettype none

module event_builder (
    input  wire                iClk,
    input  wire                iRst,
    input  wire                set,
    input  wire [3:0]          mode,
    input  wire                btn_up,
    input  wire                btn_down,
    input  wire                btn_left,
    input  wire                btn_right,
    output logic               req,
    output msg_pkg::len_t      len,
    input  wire                grant,
    input  wire msg_pkg::idx_t char_idx,
    output msg_pkg::char_t     char_out
);

    msg_pkg::event_kind_t kind;
    msg_pkg::event_kind_t next_kind;
    logic                 hit;
    logic                 accept;
    logic                 run_state;  // 1 while the stopwatch runs
    logic                 serving;
    logic                 last_read;
    logic                 clk_mode;
    logic                 sw_mode;
    msg_pkg::msg_text_t   text;

    assign clk_mode = (mode & msg_pkg::MODE_CLOCK_MASK) == 4'b0000;
    assign sw_mode  = (mode == msg_pkg::MODE_STOPWATCH);

    // Button priority is Right, Left, Down, Up
    always_comb begin
        hit       = 1'b1;
        next_kind = msg_pkg::EV_RIGHT;
        if (clk_mode && set) begin
            if (btn_right)     next_kind = msg_pkg::EV_RIGHT;
            else if (btn_left) next_kind = msg_pkg::EV_LEFT;
            else if (btn_down) next_kind = msg_pkg::EV_DOWN;
            else if (btn_up)   next_kind = msg_pkg::EV_UP;
            else               hit = 1'b0;
        end else if (sw_mode) begin
            if (btn_right)     next_kind = run_state ? msg_pkg::EV_SW_STOP : msg_pkg::EV_SW_RUN;
            else if (btn_left) next_kind = msg_pkg::EV_SW_CLEAR;
            else               hit = 1'b0;
        end else begin
            hit = 1'b0;
        end
    end

    assign accept    = hit && !req && !serving;
    assign last_read = serving && (msg_pkg::len_t'(char_idx) == len - msg_pkg::len_t'(1));

    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            kind      <= msg_pkg::EV_RIGHT;
            req       <= 1'b0;
            serving   <= 1'b0;
            run_state <= 1'b0;
        end else begin
            if (accept) begin
                kind <= next_kind;
                req  <= 1'b1;
                if (next_kind == msg_pkg::EV_SW_RUN || next_kind == msg_pkg::EV_SW_STOP) begin
                    run_state <= ~run_state;
                end
            end
            if (grant) begin
                req     <= 1'b0;
                serving <= 1'b1;
            end else if (last_read) begin
                serving <= 1'b0;
            end
        end
    end

    always_comb begin
        case (kind)
            msg_pkg::EV_RIGHT: begin
                text = msg_pkg::msg_text_t'({"Right", msg_pkg::CHAR_LF});
                len  = msg_pkg::len_t'(6);
            end
            msg_pkg::EV_LEFT: begin
                text = msg_pkg::msg_text_t'({"Left", msg_pkg::CHAR_LF});
                len  = msg_pkg::len_t'(5);
            end
            msg_pkg::EV_DOWN: begin
                text = msg_pkg::msg_text_t'({"Down", msg_pkg::CHAR_LF});
                len  = msg_pkg::len_t'(5);
            end
            msg_pkg::EV_UP: begin
                text = msg_pkg::msg_text_t'({"Up", msg_pkg::CHAR_LF});
                len  = msg_pkg::len_t'(3);
            end
            msg_pkg::EV_SW_RUN: begin
                text = msg_pkg::msg_text_t'({"Stop_Watch_RUN", msg_pkg::CHAR_LF});
                len  = msg_pkg::len_t'(15);
            end
            msg_pkg::EV_SW_STOP: begin
                text = msg_pkg::msg_text_t'({"Stop_Watch_STOP", msg_pkg::CHAR_LF});
                len  = msg_pkg::len_t'(16);
            end
            msg_pkg::EV_SW_CLEAR: begin
                text = msg_pkg::msg_text_t'({"Stop_Watch_Clear", msg_pkg::CHAR_LF});
                len  = msg_pkg::len_t'(17);
            end
            default: begin
                text = '0;
                len  = msg_pkg::len_t'(1);
            end
        endcase
    end

    assign char_out = msg_pkg::text_char(text, len, char_idx);

endmodule

`default_nettype wire

/* logic/msg_streamer.sv */
`timescale 1ns/100ps
`default_nettype none

module msg_streamer (
    input  wire                 iClk,
    input  wire                 iRst,
    input  wire                 rpt_req,
    input  wire msg_pkg::len_t  rpt_len,
    output logic                rpt_grant,
    input  wire                 evt_req,
    input  wire msg_pkg::len_t  evt_len,
    output logic                evt_grant,
    output msg_pkg::idx_t       char_idx,
    input  wire msg_pkg::char_t rpt_char,
    input  wire msg_pkg::char_t evt_char,
    output msg_pkg::char_t      tx_data,
    output logic                tx_valid
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_GAP
    } state_t;

    state_t         state;
    logic           sel_evt;   // Granted source
    msg_pkg::len_t  len_q;
    msg_pkg::char_t sel_char;
    logic           last;

    assign sel_char = sel_evt ? evt_char : rpt_char;
    assign last     = msg_pkg::len_t'(char_idx) == len_q - msg_pkg::len_t'(1);

    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            state     <= ST_IDLE;
            sel_evt   <= 1'b0;
            len_q     <= '0;
            char_idx  <= '0;
            rpt_grant <= 1'b0;
            evt_grant <= 1'b0;
            tx_valid  <= 1'b0;
        end else begin
            rpt_grant <= 1'b0;
            evt_grant <= 1'b0;
            tx_valid  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    char_idx <= '0;
                    if (evt_req) begin  // Button events first
                        evt_grant <= 1'b1;
                        sel_evt   <= 1'b1;
                        len_q     <= evt_len;
                        state     <= ST_SEND;
                    end else if (rpt_req) begin
                        rpt_grant <= 1'b1;
                        sel_evt   <= 1'b0;
                        len_q     <= rpt_len;
                        state     <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    tx_valid <= 1'b1;
                    if (last) begin
                        state <= ST_GAP;
                    end else begin
                        char_idx <= char_idx + msg_pkg::idx_t'(1);
                    end
                end
                ST_GAP:  state <= ST_IDLE;  // Last byte on the output
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge iClk) begin
        if (state == ST_SEND) begin
            tx_data <= sel_char;
        end
    end

endmodule

`default_nettype wire

/* logic/uart_msg_top.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_msg_top (
    input  wire                 iClk,
    input  wire                 iRst,
    input  wire msg_pkg::char_t rx_data,
    input  wire                 rx_valid,
    input  wire                 set,
    input  wire [3:0]           mode,
    input  wire                 btn_up,
    input  wire                 btn_down,
    input  wire                 btn_left,
    input  wire                 btn_right,
    input  wire msg_pkg::char_t hour_10,
    input  wire msg_pkg::char_t hour_1,
    input  wire msg_pkg::char_t min_10,
    input  wire msg_pkg::char_t min_1,
    input  wire msg_pkg::char_t sec_10,
    input  wire msg_pkg::char_t sec_1,
    output msg_pkg::char_t      tx_data,
    output logic                tx_valid
);

    logic           rpt_req;
    msg_pkg::len_t  rpt_len;
    logic           rpt_grant;
    msg_pkg::char_t rpt_char;

    logic           evt_req;
    msg_pkg::len_t  evt_len;
    logic           evt_grant;
    msg_pkg::char_t evt_char;

    msg_pkg::idx_t  char_idx;  // Shared read index

    report_builder u_report (
        .iClk     (iClk),
        .iRst     (iRst),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .hour_10  (hour_10),
        .hour_1   (hour_1),
        .min_10   (min_10),
        .min_1    (min_1),
        .sec_10   (sec_10),
        .sec_1    (sec_1),
        .req      (rpt_req),
        .len      (rpt_len),
        .grant    (rpt_grant),
        .char_idx (char_idx),
        .char_out (rpt_char)
    );

    event_builder u_event (
        .iClk      (iClk),
        .iRst      (iRst),
        .set       (set),
        .mode      (mode),
        .btn_up    (btn_up),
        .btn_down  (btn_down),
        .btn_left  (btn_left),
        .btn_right (btn_right),
        .req       (evt_req),
        .len       (evt_len),
        .grant     (evt_grant),
        .char_idx  (char_idx),
        .char_out  (evt_char)
    );

    msg_streamer u_streamer (
        .iClk      (iClk),
        .iRst      (iRst),
        .rpt_req   (rpt_req),
        .rpt_len   (rpt_len),
        .rpt_grant (rpt_grant),
        .evt_req   (evt_req),
        .evt_len   (evt_len),
        .evt_grant (evt_grant),
        .char_idx  (char_idx),
        .rpt_char  (rpt_char),
        .evt_char  (evt_char),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid)
    );

endmodule

`default_nettype wire

/* verification/uart_msg_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_msg_tb;

    localparam int CLK_PERIOD      = 100;
    localparam int DRIVE_DLY       = 5;    // Inputs move this long after the rising edge
    localparam int IDLE_CYCLES     = 16;   // Quiet window for stimuli that give no output
    localparam int N_MSGS          = 15;
    localparam int WATCHDOG_CYCLES =
        N_MSGS * (msg_pkg::MSG_MAX + msg_pkg::SETTLE_CYCLES + 8) + 400;

    logic           iClk = 1'b0;
    logic           iRst;
    msg_pkg::char_t rx_data;
    logic           rx_valid;
    logic           set;
    logic [3:0]     mode;
    logic           btn_up;
    logic           btn_down;
    logic           btn_left;
    logic           btn_right;
    msg_pkg::char_t dig [6];    // H10 H1 M10 M1 S10 S1
    msg_pkg::char_t tx_data;
    logic           tx_valid;

    msg_pkg::char_t exp_q [$];  // Expected bytes of all pending messages
    msg_pkg::char_t exp_byte;
    msg_pkg::char_t prev_data;
    logic           prev_valid;
    logic           run_model;  // Stopwatch run state as the TB sees it
    int             msg_count;

    uart_msg_top DUT (
        .iClk      (iClk),
        .iRst      (iRst),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .set       (set),
        .mode      (mode),
        .btn_up    (btn_up),
        .btn_down  (btn_down),
        .btn_left  (btn_left),
        .btn_right (btn_right),
        .hour_10   (dig[0]),
        .hour_1    (dig[1]),
        .min_10    (dig[2]),
        .min_1     (dig[3]),
        .sec_10    (dig[4]),
        .sec_1     (dig[5]),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid)
    );

    always #(CLK_PERIOD / 2) iClk = ~iClk;

    task automatic finish_failed();
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic abort_run(input string what);
        $display("Error at %0t: %s", $time, what);
        finish_failed();
    endtask

    task automatic value_error(input string name, input msg_pkg::char_t exp,
                               input msg_pkg::char_t act);
        $display("Fail at %0t: %s expected 0x%02h, got 0x%02h", $time, name, exp, act);
        finish_failed();
    endtask

    task automatic tick();
        @(posedge iClk);
        #DRIVE_DLY;
    endtask

    task automatic random_gap();
        repeat ($urandom_range(3, 0)) tick();
    endtask

    task automatic idle_window();
        repeat (IDLE_CYCLES) tick();  // Monitor flags any byte here
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            tick();
        end
    endtask

    // Message text plus the closing line feed
    task automatic expect_text(input string s);
        int i;
        for (i = 0; i < s.len(); i++) begin
            exp_q.push_back(s[i]);
        end
        exp_q.push_back(msg_pkg::CHAR_LF);
    endtask

    task automatic new_digits();
        foreach (dig[i]) begin
            dig[i] = 8'h30 + 8'($urandom_range(9, 0));
        end
    endtask

    task automatic expect_clock_report();
        expect_text($sformatf("Clock %c%cH %c%cM %c%cS",
                              dig[0], dig[1], dig[2], dig[3], dig[4], dig[5]));
    endtask

    task automatic expect_sw_report();
        expect_text($sformatf("Stopwatch %c%cM %c%cS %c%cmS",
                              dig[0], dig[1], dig[2], dig[3], dig[4], dig[5]));
    endtask

    task automatic send_cmd(input msg_pkg::char_t c, input logic valid);
        tick();
        rx_data  = c;
        rx_valid = valid;
        tick();
        rx_data  = 8'h00;
        rx_valid = 1'b0;
    endtask

    // Bits are Right, Left, Down, Up
    task automatic press(input logic [3:0] btns);
        tick();
        {btn_right, btn_left, btn_down, btn_up} = btns;
        tick();
        {btn_right, btn_left, btn_down, btn_up} = 4'b0000;
    endtask

    task automatic event_case(input logic [3:0] btns, input string text);
        expect_text(text);
        press(btns);
        wait_drained();
        random_gap();
    endtask

    task automatic sw_toggle();
        run_model = ~run_model;
        if (run_model) begin
            event_case(4'b1000, "Stop_Watch_RUN");
        end else begin
            event_case(4'b1000, "Stop_Watch_STOP");
        end
    endtask

    // Output monitor samples mid-cycle
    always @(negedge iClk) begin
        if (iRst) begin
            assert (tx_valid == 1'b0) else abort_run("tx_valid high during reset");
            prev_valid = 1'b0;
            prev_data  = 8'h00;
        end else begin
            if (tx_valid) begin
                assert (exp_q.size() != 0) else abort_run("byte sent with no message expected");
                assert (!(prev_valid && prev_data == msg_pkg::CHAR_LF))
                    else abort_run("no idle cycle between two messages");
                exp_byte = exp_q.pop_front();
                assert (tx_data == exp_byte) else value_error("tx_data", exp_byte, tx_data);
                if (tx_data == msg_pkg::CHAR_LF) begin
                    msg_count++;
                end
            end else begin
                assert (!(prev_valid && prev_data != msg_pkg::CHAR_LF))
                    else abort_run("tx_valid dropped in the middle of a message");
            end
            prev_valid = tx_valid;
            prev_data  = tx_data;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("watchdog expired before all messages came out");
    end

    initial begin
        void'($urandom(99));
        iRst      = 1'b1;
        rx_data   = 8'h00;
        rx_valid  = 1'b0;
        set       = 1'b0;
        mode      = 4'b0000;
        {btn_right, btn_left, btn_down, btn_up} = 4'b0000;
        run_model = 1'b0;                       // Stopped after reset
        msg_count = 0;
        new_digits();
        repeat (3) @(posedge iClk);
        #DRIVE_DLY;
        iRst = 1'b0;
        idle_window();

        new_digits();
        expect_clock_report();
        send_cmd(msg_pkg::CMD_CLOCK, 1'b1);
        wait_drained();
        random_gap();
        new_digits();
        expect_sw_report();
        send_cmd(msg_pkg::CMD_STOPWATCH, 1'b1);
        wait_drained();
        random_gap();
        send_cmd("X", 1'b1);                    // Not a command
        idle_window();
        send_cmd(msg_pkg::CMD_CLOCK, 1'b0);     // Byte without its strobe
        idle_window();

        mode = 4'b0010;
        set  = 1'b1;
        event_case(4'b1000, "Right");
        event_case(4'b0100, "Left");
        event_case(4'b0010, "Down");
        event_case(4'b0001, "Up");
        set = 1'b0;
        press(4'b1000);
        press(4'b0100);
        press(4'b0010);
        press(4'b0001);
        idle_window();

        mode = msg_pkg::MODE_STOPWATCH;
        repeat (4) sw_toggle();
        event_case(4'b0100, "Stop_Watch_Clear");

        // Button message goes first when both arrive in one cycle
        mode = 4'b0000;
        set  = 1'b1;
        new_digits();
        expect_text("Up");
        expect_sw_report();
        tick();
        rx_data  = msg_pkg::CMD_STOPWATCH;
        rx_valid = 1'b1;
        btn_up   = 1'b1;
        tick();
        rx_data  = 8'h00;
        rx_valid = 1'b0;
        btn_up   = 1'b0;
        wait_drained();

        // Both requests rise on the same edge, so the streamer must pick the event
        new_digits();
        expect_text("Down");
        expect_clock_report();
        tick();
        rx_data  = msg_pkg::CMD_CLOCK;
        rx_valid = 1'b1;
        tick();
        rx_data  = 8'h00;
        rx_valid = 1'b0;
        repeat (msg_pkg::SETTLE_CYCLES - 1) tick();
        btn_down = 1'b1;
        tick();
        btn_down = 1'b0;
        wait_drained();

        repeat (IDLE_CYCLES) tick();
        if (msg_count == N_MSGS && exp_q.size() == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abort_run($sformatf("saw %0d complete messages, expected %0d", msg_count, N_MSGS));
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
logic/msg_pkg.sv
logic/report_builder.sv
logic/event_builder.sv
logic/msg_streamer.sv
logic/uart_msg_top.sv
verification/uart_msg_tb.sv

/* Makefile */
# Verilator simulation of the UART message generator

TOP             ?= uart_msg_tb
FILELIST        ?= verilog.f
LOG             ?= sim.log
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --assert --timescale 1ns/100ps -j 0

.PHONY: sim clean

# Build, run, then decide the result from the log
sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q -F -- '>>> PASS' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
